// File: list.f
wb_pkg.sv
load_aligner.sv
rollback_arbiter.sv
writeback_select.sv
writeback_stage.sv
tb_writeback_stage.sv

// File: load_aligner.sv
//************************************************************
// Memory load path: store bypass merge, lane select,
// byte/halfword/word alignment and block endian swap
//************************************************************

`timescale 1ns/1ps

module load_aligner(
	input wb_pkg::mem_result_t dd,
	input wb_pkg::byte_mask_t sq_bypass_mask,
	input wb_pkg::line_data_t sq_bypass_data,
	output wb_pkg::scalar_t load_word,
	output wb_pkg::scalar_t scalar_load,
	output wb_pkg::vector_t block_load
);

	wb_pkg::line_data_t merged_line;
	wb_pkg::vector_t merged_words;
	logic [$clog2(wb_pkg::NUM_LANES)-1:0] word_off;
	wb_pkg::scalar_t lane_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;

	// Store queue bytes not yet in the cache win over the line
	genvar b;
	generate
		for (b = 0; b < wb_pkg::LINE_BYTES; b++)
		begin : bypass_gen
			assign merged_line[b*8 +: 8] = sq_bypass_mask[b]
				? sq_bypass_data[b*8 +: 8] : dd.load_data[b*8 +: 8];
		end
	endgenerate

	// View the line as one word per lane
	assign merged_words = merged_line;

	// Lowest address sits in the top word of the line
	assign word_off = dd.offset[$bits(wb_pkg::line_offset_t)-1:2];
	assign lane_word = merged_words[wb_pkg::NUM_LANES - 1 - word_off];

	// Big endian in memory, so offset 0 is the top byte
	always_comb
	begin
		case (dd.offset[1:0])
			2'd0: byte_aligned = lane_word[31:24];
			2'd1: byte_aligned = lane_word[23:16];
			2'd2: byte_aligned = lane_word[15:8];
			default: byte_aligned = lane_word[7:0];
		endcase
	end

	// Halfword, bytes swapped into register order
	always_comb
	begin
		if (dd.offset[1])
			half_aligned = {lane_word[7:0], lane_word[15:8]};
		else
			half_aligned = {lane_word[23:16], lane_word[31:24]};
	end

	// Every word of the line byte reversed for block loads
	genvar w;
	generate
		for (w = 0; w < wb_pkg::NUM_LANES; w++)
		begin : swap_gen
			assign block_load[w] = {merged_words[w][7:0], merged_words[w][15:8],
				merged_words[w][23:16], merged_words[w][31:24]};
		end
	endgenerate

	// Full word load is the swapped copy of the selected lane
	assign load_word = block_load[wb_pkg::NUM_LANES - 1 - word_off];

	// Zero or sign extension by access type
	always_comb
	begin
		case (dd.info.mem_op)
			wb_pkg::MEM_B: scalar_load = {24'b0, byte_aligned};
			wb_pkg::MEM_BX: scalar_load = {{24{byte_aligned[7]}}, byte_aligned};
			wb_pkg::MEM_S: scalar_load = {16'b0, half_aligned};
			wb_pkg::MEM_SX: scalar_load = {{16{half_aligned[15]}}, half_aligned};
			default: scalar_load = load_word;
		endcase
	end

endmodule

// File: rollback_arbiter.sv
//************************************************************
// Prioritized rollback and fault select for the retiring
// instruction, plus the memory thread suspend one-hot
//************************************************************

`timescale 1ns/1ps

module rollback_arbiter(
	input wb_pkg::exec_result_t ix,
	input logic ix_rollback_en,
	input wb_pkg::scalar_t ix_rollback_pc,
	input wb_pkg::mem_result_t dd,
	input logic sq_rollback_en,
	input wb_pkg::scalar_t fault_handler,
	input wb_pkg::scalar_t load_word,
	output wb_pkg::rollback_t rollback,
	output wb_pkg::fault_t fault,
	output wb_pkg::thread_bitmap_t suspend_thread_oh
);

	logic ix_pc_write;
	logic dd_pc_load;

	// Scalar write to the PC register from the integer pipe
	assign ix_pc_write = ix.valid && ix.info.has_dest && !ix.info.dest_is_vector
		&& ix.info.dest_reg == wb_pkg::reg_idx_t'(wb_pkg::REG_PC);

	// Load into PC unless the access missed and replays as a memory rollback
	assign dd_pc_load = dd.valid && dd.info.is_load && dd.info.has_dest
		&& !dd.info.dest_is_vector && !dd.rollback_en
		&& dd.info.dest_reg == wb_pkg::reg_idx_t'(wb_pkg::REG_PC);

	// Only one rollback leaves the stage per cycle
	always_comb
	begin
		rollback = '0;
		rollback.pipeline = wb_pkg::PIPE_SCYCLE;
		fault = '0;
		fault.reason = wb_pkg::FR_NONE;

		if (ix.valid && ix.info.illegal)
		begin
			// Illegal instruction traps to the handler
			rollback.en = 1'b1;
			rollback.thread = ix.thread;
			rollback.pc = fault_handler;
			fault.en = 1'b1;
			fault.reason = wb_pkg::FR_ILLEGAL;
			fault.pc = ix.info.pc;
			fault.thread = ix.thread;
		end
		else if (dd.valid && dd.access_fault)
		begin
			// Bad address reported to the handler
			rollback.en = 1'b1;
			rollback.thread = dd.thread;
			rollback.pc = fault_handler;
			rollback.pipeline = wb_pkg::PIPE_MEM;
			fault.en = 1'b1;
			fault.reason = wb_pkg::FR_ACCESS;
			fault.pc = dd.info.pc;
			fault.thread = dd.thread;
			fault.access_addr = dd.addr;
		end
		else if (ix_pc_write)
		begin
			rollback.en = 1'b1;
			rollback.thread = ix.thread;
			rollback.pc = ix.result[0];
		end
		else if (dd_pc_load)
		begin
			rollback.en = 1'b1;
			rollback.thread = dd.thread;
			rollback.pc = load_word;
			rollback.pipeline = wb_pkg::PIPE_MEM;
		end
		else if (ix.valid && ix_rollback_en)
		begin
			// Taken branch
			rollback.en = 1'b1;
			rollback.thread = ix.thread;
			rollback.pc = ix_rollback_pc;
			rollback.subcycle = ix.subcycle;
		end
		else if (dd.valid && (dd.rollback_en || sq_rollback_en))
		begin
			// Cache miss or full store queue replays the access
			rollback.en = 1'b1;
			rollback.thread = dd.thread;
			rollback.pc = dd.rollback_pc;
			rollback.pipeline = wb_pkg::PIPE_MEM;
			rollback.subcycle = dd.subcycle;
		end
	end

	// Park the memory thread until its miss or store drains
	assign suspend_thread_oh = (dd.suspend || sq_rollback_en)
		? wb_pkg::thread_bitmap_t'(1) << dd.thread : '0;

	// Store queue only rolls back an instruction that is retiring
	always_comb
	begin
		assert final (!sq_rollback_en || dd.valid)
		else $error("sq_rollback_en without dd.valid");
	end

endmodule

// File: tb_writeback_stage.sv
//************************************************************
// Random-stimulus testbench for the writeback stage with a
// reference model, a value checker and edge timeouts
//************************************************************

`timescale 1ns/1ps

module tb_writeback_stage;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_CYCLES = 2000;
	// Generous bound on the whole run, in ns
	localparam int TIME_LIMIT = NUM_CYCLES * CLK_PERIOD * 2;
	localparam int EDGE_TIMEOUT = CLK_PERIOD * 4;
	localparam logic [31:0] SEED = 32'h52f5;

	logic clk;
	logic reset;
	wb_pkg::exec_result_t ix;
	logic ix_rollback_en;
	wb_pkg::scalar_t ix_rollback_pc;
	wb_pkg::exec_result_t fx;
	wb_pkg::mem_result_t dd;
	wb_pkg::byte_mask_t sq_bypass_mask;
	wb_pkg::line_data_t sq_bypass_data;
	logic sq_rollback_en;
	wb_pkg::scalar_t fault_handler;
	wb_pkg::rollback_t rollback;
	wb_pkg::fault_t fault;
	wb_pkg::thread_bitmap_t suspend_thread_oh;
	wb_pkg::writeback_t wb;

	// Model outputs
	wb_pkg::rollback_t exp_rollback;
	wb_pkg::fault_t exp_fault;
	wb_pkg::thread_bitmap_t exp_suspend;
	wb_pkg::writeback_t exp_wb;
	wb_pkg::writeback_t next_wb;
	logic edge_seen;
	int cycle;

	writeback_stage u_dut(
		.clk(clk),
		.reset(reset),
		.ix(ix),
		.ix_rollback_en(ix_rollback_en),
		.ix_rollback_pc(ix_rollback_pc),
		.fx(fx),
		.dd(dd),
		.sq_bypass_mask(sq_bypass_mask),
		.sq_bypass_data(sq_bypass_data),
		.sq_rollback_en(sq_rollback_en),
		.fault_handler(fault_handler),
		.rollback(rollback),
		.fault(fault),
		.suspend_thread_oh(suspend_thread_oh),
		.wb(wb)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_run(input string reason);
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [255:0] actual,
		input logic [255:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns %s: got %h expected %h", $time, name, actual, expected);
			stop_run("output mismatch");
		end
	endtask

	// Bounded wait for the next falling edge
	task automatic wait_falling();
		edge_seen = 1'b0;
		fork
			begin
				@(negedge clk);
				edge_seen = 1'b1;
			end
			#(EDGE_TIMEOUT);
		join_any
		disable fork;
		if (!edge_seen)
		begin
			$display("Timed out waiting for a falling clock edge");
			stop_run("clock edge timeout");
		end
	endtask

	function automatic wb_pkg::scalar_t byte_swap(input wb_pkg::scalar_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic wb_pkg::vector_t random_vector();
		wb_pkg::vector_t v;

		for (int i = 0; i < wb_pkg::NUM_LANES; i++)
			v[i] = $urandom;
		return v;
	endfunction

	// Decoded fields, dest biased toward the PC and scalar registers
	function automatic wb_pkg::instr_info_t random_info();
		wb_pkg::instr_info_t info;

		info.pc = $urandom;
		info.has_dest = ($urandom % 4) != 0;
		info.dest_reg = ($urandom % 4 == 0) ? wb_pkg::reg_idx_t'(wb_pkg::REG_PC)
			: wb_pkg::reg_idx_t'($urandom);
		info.dest_is_vector = ($urandom % 4) == 0;
		info.is_compare = ($urandom % 4) == 0;
		info.is_call = ($urandom % 8) == 0;
		info.illegal = ($urandom % 16) == 0;
		info.is_load = 1'b0;
		info.mem_op = wb_pkg::mem_op_t'($urandom % 6);
		info.last_subcycle = wb_pkg::subcycle_t'($urandom);
		return info;
	endfunction

	// One pipeline or none retires this cycle
	task automatic drive_random();
		int pick;

		pick = $urandom % 4;
		ix = '0;
		ix.info = random_info();
		ix.thread = wb_pkg::thread_idx_t'($urandom);
		ix.subcycle = wb_pkg::subcycle_t'($urandom);
		ix.mask = wb_pkg::lane_mask_t'($urandom);
		ix.result = random_vector();
		ix.valid = pick == 1;
		fx = '0;
		fx.info = random_info();
		fx.thread = wb_pkg::thread_idx_t'($urandom);
		fx.subcycle = wb_pkg::subcycle_t'($urandom);
		fx.mask = wb_pkg::lane_mask_t'($urandom);
		fx.result = random_vector();
		fx.valid = pick == 2;
		dd = '0;
		dd.info = random_info();
		dd.info.is_load = ($urandom % 4) != 0;
		// Loads always target a register, stores never do
		dd.info.has_dest = dd.info.is_load;
		dd.info.dest_is_vector = dd.info.mem_op == wb_pkg::MEM_BLOCK;
		dd.thread = wb_pkg::thread_idx_t'($urandom);
		dd.subcycle = wb_pkg::subcycle_t'($urandom);
		dd.lane_mask = wb_pkg::lane_mask_t'($urandom);
		dd.offset = wb_pkg::line_offset_t'($urandom);
		dd.addr = $urandom;
		dd.load_data = random_vector();
		dd.rollback_en = ($urandom % 8) == 0;
		dd.rollback_pc = $urandom;
		dd.suspend = ($urandom % 8) == 0;
		dd.access_fault = ($urandom % 16) == 0;
		dd.valid = pick == 3;
		ix_rollback_en = ($urandom % 4) == 0;
		ix_rollback_pc = $urandom;
		sq_bypass_mask = wb_pkg::byte_mask_t'($urandom);
		sq_bypass_data = random_vector();
		sq_rollback_en = dd.valid && ($urandom % 8) == 0;
		fault_handler = $urandom;
	endtask

	// Expected same-cycle outputs and the write that follows one cycle later
	task automatic model_outputs();
		wb_pkg::line_data_t line;
		wb_pkg::scalar_t lane;
		logic [7:0] lane_bytes [4];
		wb_pkg::scalar_t ld_word;
		wb_pkg::scalar_t sc_load;
		wb_pkg::vector_t blk;
		int idx;
		int hb;

		for (int b = 0; b < wb_pkg::LINE_BYTES; b++)
			line[b*8 +: 8] = sq_bypass_mask[b] ? sq_bypass_data[b*8 +: 8]
				: dd.load_data[b*8 +: 8];
		idx = wb_pkg::NUM_LANES - 1 - int'(dd.offset[3:2]);
		lane = line[idx*32 +: 32];
		// Byte k of the word sits at memory offset k
		for (int k = 0; k < 4; k++)
			lane_bytes[k] = lane[31 - 8*k -: 8];
		ld_word = {lane_bytes[3], lane_bytes[2], lane_bytes[1], lane_bytes[0]};
		for (int w = 0; w < wb_pkg::NUM_LANES; w++)
			blk[w] = byte_swap(line[w*32 +: 32]);
		hb = dd.offset[1] ? 2 : 0;
		case (dd.info.mem_op)
			wb_pkg::MEM_B: sc_load = {24'b0, lane_bytes[dd.offset[1:0]]};
			wb_pkg::MEM_BX: sc_load = {{24{lane_bytes[dd.offset[1:0]][7]}},
				lane_bytes[dd.offset[1:0]]};
			wb_pkg::MEM_S: sc_load = {16'b0, lane_bytes[hb+1], lane_bytes[hb]};
			wb_pkg::MEM_SX: sc_load = {{16{lane_bytes[hb+1][7]}}, lane_bytes[hb+1],
				lane_bytes[hb]};
			default: sc_load = ld_word;
		endcase

		// Six rollback causes, highest first
		exp_rollback = '0;
		exp_fault = '0;
		if (ix.valid && ix.info.illegal)
		begin
			exp_rollback = '{1'b1, ix.thread, fault_handler, wb_pkg::PIPE_SCYCLE, 2'd0};
			exp_fault = '{1'b1, wb_pkg::FR_ILLEGAL, ix.info.pc, ix.thread, 32'd0};
		end
		else if (dd.valid && dd.access_fault)
		begin
			exp_rollback = '{1'b1, dd.thread, fault_handler, wb_pkg::PIPE_MEM, 2'd0};
			exp_fault = '{1'b1, wb_pkg::FR_ACCESS, dd.info.pc, dd.thread, dd.addr};
		end
		else if (ix.valid && ix.info.has_dest && !ix.info.dest_is_vector
			&& ix.info.dest_reg == wb_pkg::REG_PC)
			exp_rollback = '{1'b1, ix.thread, ix.result[0], wb_pkg::PIPE_SCYCLE, 2'd0};
		else if (dd.valid && dd.info.is_load && dd.info.has_dest && !dd.info.dest_is_vector
			&& dd.info.dest_reg == wb_pkg::REG_PC && !dd.rollback_en)
			exp_rollback = '{1'b1, dd.thread, ld_word, wb_pkg::PIPE_MEM, 2'd0};
		else if (ix.valid && ix_rollback_en)
			exp_rollback = '{1'b1, ix.thread, ix_rollback_pc, wb_pkg::PIPE_SCYCLE,
				ix.subcycle};
		else if (dd.valid && (dd.rollback_en || sq_rollback_en))
			exp_rollback = '{1'b1, dd.thread, dd.rollback_pc, wb_pkg::PIPE_MEM, dd.subcycle};
		exp_suspend = (dd.suspend || sq_rollback_en) ? wb_pkg::thread_bitmap_t'(1 << dd.thread)
			: '0;

		next_wb = '0;
		if (ix.valid || fx.valid)
		begin
			next_wb.en = ix.valid ? ix.info.is_call || (ix.info.has_dest && !exp_rollback.en)
				: fx.info.has_dest && !exp_rollback.en;
			next_wb.thread = ix.valid ? ix.thread : fx.thread;
			next_wb.is_vector = ix.valid ? ix.info.dest_is_vector : fx.info.dest_is_vector;
			next_wb.value = ix.valid ? ix.result : fx.result;
			next_wb.mask = ix.valid ? ix.mask : fx.mask;
			next_wb.dest_reg = ix.valid ? ix.info.dest_reg : fx.info.dest_reg;
			next_wb.is_last_subcycle = ix.valid ? ix.subcycle == ix.info.last_subcycle
				: fx.subcycle == fx.info.last_subcycle;
			// Compares keep one bit per lane, all in lane 0
			if (ix.valid ? ix.info.is_compare : fx.info.is_compare)
			begin
				blk = next_wb.value;
				next_wb.value = '0;
				for (int i = 0; i < wb_pkg::NUM_LANES; i++)
					next_wb.value[0][i] = blk[i][0];
			end
		end
		else if (dd.valid)
		begin
			next_wb.en = dd.info.has_dest && !exp_rollback.en;
			next_wb.thread = dd.thread;
			next_wb.is_vector = dd.info.dest_is_vector;
			next_wb.dest_reg = dd.info.dest_reg;
			next_wb.is_last_subcycle = dd.subcycle == dd.info.last_subcycle;
			next_wb.value = (dd.info.mem_op == wb_pkg::MEM_BLOCK) ? blk
				: wb_pkg::vector_t'(sc_load);
			next_wb.mask = (dd.info.mem_op == wb_pkg::MEM_BLOCK) ? dd.lane_mask : '1;
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		reset = 1'b1;
		ix = '0;
		ix_rollback_en = 1'b0;
		ix_rollback_pc = '0;
		fx = '0;
		dd = '0;
		sq_bypass_mask = '0;
		sq_bypass_data = '0;
		sq_rollback_en = 1'b0;
		fault_handler = '0;
		exp_wb = '0;
		edge_seen = 1'b0;
		cycle = 0;
		repeat (2) wait_falling();
		reset = 1'b0;

		while (cycle < NUM_CYCLES && $time < TIME_LIMIT)
		begin
			wait_falling();
			// Write from last cycle's retire
			check_value("wb.en", wb.en, exp_wb.en);
			if (exp_wb.en)
				check_value("wb", wb, exp_wb);
			drive_random();
			#2;
			model_outputs();
			check_value("rollback", rollback, exp_rollback);
			check_value("fault", fault, exp_fault);
			check_value("suspend_thread_oh", suspend_thread_oh, exp_suspend);
			exp_wb = next_wb;
			cycle++;
		end

		if (cycle == NUM_CYCLES)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("Run hit its time limit after %0d cycles", cycle);
			stop_run("run time limit");
		end
	end

endmodule

// File: wb_pkg.sv
//************************************************************
// Shared widths, enums and bus structs for the
// writeback stage of the vector core
//************************************************************

package wb_pkg;

	// Core geometry
	localparam int NUM_LANES = 4;
	localparam int NUM_THREADS = 4;
	// One 32-bit word per lane in a line
	localparam int LINE_BYTES = NUM_LANES * 4;
	localparam int NUM_REGS = 32;
	// Writes to this register redirect the thread
	localparam int REG_PC = 31;

	// Datapath widths
	typedef logic [31:0] scalar_t;
	typedef scalar_t [NUM_LANES-1:0] vector_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [$clog2(NUM_THREADS)-1:0] thread_idx_t;
	typedef logic [NUM_THREADS-1:0] thread_bitmap_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [1:0] subcycle_t;
	typedef logic [LINE_BYTES*8-1:0] line_data_t;
	typedef logic [LINE_BYTES-1:0] byte_mask_t;
	typedef logic [$clog2(LINE_BYTES)-1:0] line_offset_t;

	// Load access types, X variants sign extend
	typedef enum logic [2:0] {
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK
	} mem_op_t;

	// Source pipeline of a rollback
	typedef enum logic [1:0] {
		PIPE_SCYCLE,
		PIPE_MCYCLE,
		PIPE_MEM
	} pipeline_sel_t;

	typedef enum logic [1:0] {
		FR_NONE,
		FR_ILLEGAL,
		FR_ACCESS
	} fault_reason_t;

	// Decoded instruction fields that reach writeback
	typedef struct packed {
		scalar_t pc;
		logic has_dest;
		reg_idx_t dest_reg;
		logic dest_is_vector;
		logic is_compare;
		logic is_call;
		logic illegal;
		logic is_load;
		mem_op_t mem_op;
		subcycle_t last_subcycle;
	} instr_info_t;

	// Retire bundle of the integer and floating point pipelines
	typedef struct packed {
		logic valid;
		instr_info_t info;
		thread_idx_t thread;
		subcycle_t subcycle;
		lane_mask_t mask;
		vector_t result;
	} exec_result_t;

	// Retire bundle of the memory pipeline
	typedef struct packed {
		logic valid;
		instr_info_t info;
		thread_idx_t thread;
		subcycle_t subcycle;
		lane_mask_t lane_mask;
		line_offset_t offset;
		scalar_t addr;
		line_data_t load_data;
		logic rollback_en;
		scalar_t rollback_pc;
		logic suspend;
		logic access_fault;
	} mem_result_t;

	typedef struct packed {
		logic en;
		thread_idx_t thread;
		scalar_t pc;
		pipeline_sel_t pipeline;
		subcycle_t subcycle;
	} rollback_t;

	typedef struct packed {
		logic en;
		fault_reason_t reason;
		scalar_t pc;
		thread_idx_t thread;
		scalar_t access_addr;
	} fault_t;

	// Register file write port
	typedef struct packed {
		logic en;
		thread_idx_t thread;
		logic is_vector;
		vector_t value;
		lane_mask_t mask;
		reg_idx_t dest_reg;
		logic is_last_subcycle;
	} writeback_t;

endpackage

// File: writeback_select.sv
//************************************************************
// Registered register file write from the one retiring
// pipeline, with compare packing and load formatting
//************************************************************

`timescale 1ns/1ps

module writeback_select(
	input clk,
	input reset,
	input wb_pkg::exec_result_t ix,
	input wb_pkg::exec_result_t fx,
	input wb_pkg::mem_result_t dd,
	input wb_pkg::scalar_t scalar_load,
	input wb_pkg::vector_t block_load,
	input logic rollback_en,
	output wb_pkg::writeback_t wb
);

	wb_pkg::writeback_t wb_next;
	wb_pkg::writeback_t wb_hold;
	logic wb_en;

	// Bit 0 of every lane, gathered into lane 0
	function automatic wb_pkg::vector_t pack_compare(input wb_pkg::vector_t result);
		wb_pkg::lane_mask_t bits;

		for (int i = 0; i < wb_pkg::NUM_LANES; i++)
			bits[i] = result[i][0];
		return wb_pkg::vector_t'(bits);
	endfunction

	always_comb
	begin
		// Payload holds unless a pipeline retires
		wb_next = wb_hold;
		wb_next.en = 1'b0;

		if (ix.valid)
		begin
			// A call writes its link register even while it rolls back
			wb_next.en = ix.info.is_call || (ix.info.has_dest && !rollback_en);
			wb_next.thread = ix.thread;
			wb_next.is_vector = ix.info.dest_is_vector;
			wb_next.value = ix.info.is_compare ? pack_compare(ix.result) : ix.result;
			wb_next.mask = ix.mask;
			wb_next.dest_reg = ix.info.dest_reg;
			wb_next.is_last_subcycle = ix.subcycle == ix.info.last_subcycle;
		end
		else if (fx.valid)
		begin
			wb_next.en = fx.info.has_dest && !rollback_en;
			wb_next.thread = fx.thread;
			wb_next.is_vector = fx.info.dest_is_vector;
			wb_next.value = fx.info.is_compare ? pack_compare(fx.result) : fx.result;
			wb_next.mask = fx.mask;
			wb_next.dest_reg = fx.info.dest_reg;
			wb_next.is_last_subcycle = fx.subcycle == fx.info.last_subcycle;
		end
		else if (dd.valid)
		begin
			wb_next.en = dd.info.has_dest && !rollback_en;
			wb_next.thread = dd.thread;
			wb_next.is_vector = dd.info.dest_is_vector;
			wb_next.dest_reg = dd.info.dest_reg;
			wb_next.is_last_subcycle = dd.subcycle == dd.info.last_subcycle;
			if (dd.info.is_load)
			begin
				if (dd.info.mem_op == wb_pkg::MEM_BLOCK)
				begin
					// Block load fills the enabled lanes
					wb_next.value = block_load;
					wb_next.mask = dd.lane_mask;
				end
				else
				begin
					// Scalar load lands in lane 0
					wb_next.value = wb_pkg::vector_t'(scalar_load);
					wb_next.mask = '1;
				end
			end
		end
	end

	// Write enable
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wb_en <= 1'b0;
		else
			wb_en <= wb_next.en;
	end

	// Data fields
	always_ff @(posedge clk)
	begin
		wb_hold <= wb_next;
	end

	always_comb
	begin
		wb = wb_hold;
		wb.en = wb_en;
	end

	// Environment retires one instruction per cycle at most
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({ix.valid, fx.valid, dd.valid}));

	// A load always targets a register
	assert property (@(posedge clk) disable iff (reset)
		dd.valid && dd.info.is_load |-> dd.info.has_dest);

endmodule

// File: writeback_stage.sv
//************************************************************
// Writeback stage top: load alignment, rollback select
// and the registered register file write
//************************************************************

`timescale 1ns/1ps

module writeback_stage(
	input clk,
	input reset,
	input wb_pkg::exec_result_t ix,
	input logic ix_rollback_en,
	input wb_pkg::scalar_t ix_rollback_pc,
	input wb_pkg::exec_result_t fx,
	input wb_pkg::mem_result_t dd,
	input wb_pkg::byte_mask_t sq_bypass_mask,
	input wb_pkg::line_data_t sq_bypass_data,
	input logic sq_rollback_en,
	input wb_pkg::scalar_t fault_handler,
	output wb_pkg::rollback_t rollback,
	output wb_pkg::fault_t fault,
	output wb_pkg::thread_bitmap_t suspend_thread_oh,
	output wb_pkg::writeback_t wb
);

	// Aligned load results
	wb_pkg::scalar_t load_word;
	wb_pkg::scalar_t scalar_load;
	wb_pkg::vector_t block_load;

	load_aligner u_load_aligner(
		.dd(dd),
		.sq_bypass_mask(sq_bypass_mask),
		.sq_bypass_data(sq_bypass_data),
		.load_word(load_word),
		.scalar_load(scalar_load),
		.block_load(block_load)
	);

	// Same cycle rollback, fault and suspend
	rollback_arbiter u_rollback_arbiter(
		.ix(ix),
		.ix_rollback_en(ix_rollback_en),
		.ix_rollback_pc(ix_rollback_pc),
		.dd(dd),
		.sq_rollback_en(sq_rollback_en),
		.fault_handler(fault_handler),
		.load_word(load_word),
		.rollback(rollback),
		.fault(fault),
		.suspend_thread_oh(suspend_thread_oh)
	);

	// Register write one cycle after retire
	writeback_select u_writeback_select(
		.clk(clk),
		.reset(reset),
		.ix(ix),
		.fx(fx),
		.dd(dd),
		.scalar_load(scalar_load),
		.block_load(block_load),
		.rollback_en(rollback.en),
		.wb(wb)
	);

endmodule
